//--- common/c1Pkg.sv
`default_nettype none

package c1Pkg;

	// Byte lane carried on the 68000 data pins
	localparam int dataW = 8;

	// Decoded region of the current 68000 cycle
	typedef enum logic [4:0] {
		zRom,
		zWram,
		zPort,
		zCtrl1,
		zIcom,
		zCtrl2,
		zDip0,
		zDip1,
		zBitw0,
		zBitw1,
		zStatusB,
		zLspc,
		zPal,
		zCard,
		zSrom,
		zSram,
		zNone
	} zoneT;

	// Segment codes on {a23, a22}
	localparam logic [1:0] segMain = 2'b00;
	localparam logic [1:0] segPal = 2'b01;
	localparam logic [1:0] segCard = 2'b10;
	localparam logic [1:0] segSys = 2'b11;

	// Blocks on addr[20:19] inside the main segment
	localparam logic [1:0] blkRom = 2'b00;
	localparam logic [1:0] blkWram = 2'b01;
	localparam logic [1:0] blkPort = 2'b10;
	localparam logic [1:0] blkIo = 2'b11;

	// Blocks on addr[20:19] inside the system segment
	localparam logic [1:0] blkSrom = 2'b00;
	localparam logic [1:0] blkSram = 2'b01;

	// I/O registers, on addr[18:16] or addr[18:17]
	localparam logic [2:0] ioCtrl1 = 3'b000;
	localparam logic [2:0] ioIcom = 3'b001;
	localparam logic [1:0] ioCtrl2 = 2'b01;
	localparam logic [2:0] ioStat0 = 3'b100;
	localparam logic [2:0] ioStat1 = 3'b101;
	localparam logic [1:0] ioLspc = 2'b11;

	// Status B bit 7, cabinet variant
	localparam logic consoleMode = 1'b1;

	// Wait states per cycle
	localparam logic [1:0] cardWaits = 2'd2;
	localparam logic [1:0] romWaits = 2'd1;

endpackage

`default_nettype wire

//--- decode/addrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module addrDecode (
	input wire [20:16] addr,
	input wire a22,
	input wire a23,
	input wire ldsN,
	input wire udsN,
	input wire rw,
	input wire asN,
	output c1Pkg::zoneT zone,
	output logic ctrl1Sel,
	output logic ctrl2Sel,
	output logic statusSel,
	output logic icomSel,
	output logic romOeL,
	output logic romOeU,
	output logic portOeL,
	output logic portOeU,
	output logic portWeL,
	output logic portWeU,
	output logic portAdrsN,
	output logic wrL,
	output logic wrU,
	output logic wwL,
	output logic wwU,
	output logic sromOeL,
	output logic sromOeU,
	output logic sramOeL,
	output logic sramOeU,
	output logic sramWeL,
	output logic sramWeU,
	output logic lspOeN,
	output logic lspWeN,
	output logic crdOeN,
	output logic crdWeN,
	output logic crdCN,
	output logic bitW0N,
	output logic bitW1N,
	output logic dipRd0N,
	output logic dipRd1N,
	output logic palN
);

	logic act;
	logic word;
	logic laneRdL, laneRdU, laneWrL, laneWrU;
	logic inMain, inPal, inCard, inSys;
	logic inRom, inWram, inPort, inIo;
	logic inCtrl1, inIcom, inCtrl2, inStat0, inStat1, inLspc;
	logic inSrom, inSram;

	// Every strobe is qualified by address strobe
	assign act = !asN;
	assign word = !ldsN && !udsN;
	assign laneRdL = act && rw && !ldsN;
	assign laneRdU = act && rw && !udsN;
	assign laneWrL = act && !rw && !ldsN;
	assign laneWrU = act && !rw && !udsN;

	assign inMain = {a23, a22} == c1Pkg::segMain;
	assign inPal = {a23, a22} == c1Pkg::segPal;
	assign inCard = {a23, a22} == c1Pkg::segCard;
	assign inSys = {a23, a22} == c1Pkg::segSys;

	assign inRom = inMain && addr[20:19] == c1Pkg::blkRom;
	assign inWram = inMain && addr[20:19] == c1Pkg::blkWram;
	assign inPort = inMain && addr[20:19] == c1Pkg::blkPort;
	assign inIo = inMain && addr[20:19] == c1Pkg::blkIo;

	// Register window, 3xxxxx
	assign inCtrl1 = inIo && addr[18:16] == c1Pkg::ioCtrl1;
	assign inIcom = inIo && addr[18:16] == c1Pkg::ioIcom;
	assign inCtrl2 = inIo && addr[18:17] == c1Pkg::ioCtrl2;
	assign inStat0 = inIo && addr[18:16] == c1Pkg::ioStat0;
	assign inStat1 = inIo && addr[18:16] == c1Pkg::ioStat1;
	assign inLspc = inIo && addr[18:17] == c1Pkg::ioLspc;

	assign inSrom = inSys && addr[20:19] == c1Pkg::blkSrom;
	assign inSram = inSys && addr[20:19] == c1Pkg::blkSram;

	// One zone per cycle; the upper lane wins in the register window
	always_comb
	begin
		zone = c1Pkg::zNone;
		if (act)
		begin
			if (inRom)
				zone = c1Pkg::zRom;
			else if (inWram)
				zone = c1Pkg::zWram;
			else if (inPort)
				zone = c1Pkg::zPort;
			else if (inCtrl1)
				zone = !udsN ? c1Pkg::zCtrl1 : (rw ? c1Pkg::zDip0 : c1Pkg::zNone);
			else if (inIcom)
				zone = !udsN ? c1Pkg::zIcom : (rw ? c1Pkg::zDip1 : c1Pkg::zNone);
			else if (inCtrl2)
				zone = c1Pkg::zCtrl2;
			else if (inStat0)
				zone = !udsN ? c1Pkg::zStatusB : (!rw ? c1Pkg::zBitw0 : c1Pkg::zNone);
			else if (inStat1)
				zone = !udsN ? c1Pkg::zStatusB : (!rw ? c1Pkg::zBitw1 : c1Pkg::zNone);
			else if (inLspc)
				zone = c1Pkg::zLspc;
			else if (inPal)
				zone = c1Pkg::zPal;
			else if (inCard)
				zone = c1Pkg::zCard;
			else if (inSrom)
				zone = c1Pkg::zSrom;
			else if (inSram)
				zone = c1Pkg::zSram;
		end
	end

	// Register selects, even byte only
	assign ctrl1Sel = act && !udsN && inCtrl1;
	assign ctrl2Sel = act && !udsN && inCtrl2;
	assign statusSel = act && !udsN && (inStat0 || inStat1);
	assign icomSel = act && !udsN && inIcom;

	assign romOeL = !(inRom && laneRdL);
	assign romOeU = !(inRom && laneRdU);
	assign portOeL = !(inPort && laneRdL);
	assign portOeU = !(inPort && laneRdU);
	assign portWeL = !(inPort && laneWrL);
	assign portWeU = !(inPort && laneWrU);
	assign portAdrsN = !(inPort && act);
	assign wrL = !(inWram && laneRdL);
	assign wrU = !(inWram && laneRdU);
	assign wwL = !(inWram && laneWrL);
	assign wwU = !(inWram && laneWrU);
	assign sromOeL = !(inSrom && laneRdL);
	assign sromOeU = !(inSrom && laneRdU);
	assign sramOeL = !(inSram && laneRdL);
	assign sramOeU = !(inSram && laneRdU);
	assign sramWeL = !(inSram && laneWrL);
	assign sramWeU = !(inSram && laneWrU);

	// LSPC and card want a full word
	assign lspOeN = !(inLspc && act && rw && word);
	assign lspWeN = !(inLspc && act && !rw && word);
	assign crdOeN = !(inCard && act && rw && word);
	assign crdWeN = !(inCard && act && !rw && word);
	assign crdCN = crdOeN && crdWeN;

	// Odd byte strobes toward the dipswitch and bit-write logic
	assign dipRd0N = !(inCtrl1 && laneRdL);
	assign dipRd1N = !(inIcom && laneRdL);
	assign bitW0N = !(inStat0 && laneWrL);
	assign bitW1N = !(inStat1 && laneWrL);
	assign palN = !(inPal && act);

endmodule

`default_nettype wire

//--- io/ioRegs.sv
`timescale 1ns/1ps
`default_nettype none

module ioRegs (
	input wire CLK_68KCLK,
	input wire rstN,
	input wire asN,
	input wire rw,
	input wire ctrl1Sel,
	input wire ctrl2Sel,
	input wire statusSel,
	input wire icomSel,
	input wire [c1Pkg::dataW-1:0] dataIn,
	input wire [9:0] p1In,
	input wire [9:0] p2In,
	input wire cd1N,
	input wire cd2N,
	input wire wpN,
	input wire [c1Pkg::dataW-1:0] sdd,
	input wire sddWr,
	output logic [c1Pkg::dataW-1:0] dataOut,
	output logic dataOe,
	output logic [c1Pkg::dataW-1:0] soundCmd,
	output logic sdwN
);

	logic inCycle;
	logic cycleStart;
	logic cmdWr;
	logic sdwPend;
	logic [c1Pkg::dataW-1:0] replyLatch;

	// First edge of an asN low period
	assign cycleStart = !asN && !inCycle;
	assign cmdWr = cycleStart && icomSel && !rw;

	always_ff @(posedge CLK_68KCLK)
	begin
		if (!rstN)
		begin
			inCycle <= 1'b0;
			sdwPend <= 1'b0;
			sdwN <= 1'b1;
			soundCmd <= '0;
			replyLatch <= '0;
		end
		else
		begin
			inCycle <= !asN;
			// Strobe to the sound CPU one edge after the capture
			sdwPend <= cmdWr;
			sdwN <= !sdwPend;
			if (cmdWr)
				soundCmd <= dataIn;
			if (sddWr)
				replyLatch <= sdd;
		end
	end

	// Read side
	always_comb
	begin
		dataOut = '0;
		if (ctrl1Sel)
			dataOut = p1In[7:0];
		else if (ctrl2Sel)
			dataOut = p2In[7:0];
		else if (statusSel)
			dataOut = {c1Pkg::consoleMode, wpN, cd2N, cd1N, p2In[9:8], p1In[9:8]};
		else if (icomSel)
			dataOut = replyLatch;
	end

	assign dataOe = rw && !asN && (ctrl1Sel || ctrl2Sel || statusSel || icomSel);

endmodule

`default_nettype wire

//--- hw/waitGen.sv
`timescale 1ns/1ps
`default_nettype none

module waitGen (
	input wire CLK_68KCLK,
	input wire rstN,
	input wire asN,
	input wire c1Pkg::zoneT zone,
	input wire romWait,
	input wire pWait0,
	input wire pWait1,
	output logic dtackN
);

	typedef enum logic [1:0] {
		sIdle,
		sCount,
		sAcked
	} stateT;

	stateT state;
	logic [1:0] count;
	logic [1:0] loadVal;

	// Wait states for the zone of this cycle
	always_comb
	begin
		case (zone)
			c1Pkg::zRom: loadVal = romWait ? c1Pkg::romWaits : 2'd0;
			c1Pkg::zPort: loadVal = {pWait1, pWait0};
			c1Pkg::zCard: loadVal = c1Pkg::cardWaits;
			default: loadVal = 2'd0;
		endcase
	end

	always_ff @(posedge CLK_68KCLK)
	begin
		if (!rstN)
		begin
			state <= sIdle;
			count <= 2'd0;
			dtackN <= 1'b1;
		end
		else
		begin
			case (state)
				sIdle:
				begin
					if (!asN)
					begin
						count <= loadVal;
						state <= sCount;
					end
				end
				sCount:
				begin
					// asN high here means the cycle was aborted
					if (asN)
					begin
						count <= 2'd0;
						state <= sIdle;
					end
					else if (count == 2'd0)
					begin
						dtackN <= 1'b0;
						state <= sAcked;
					end
					else
						count <= count - 2'd1;
				end
				sAcked:
				begin
					if (asN)
					begin
						dtackN <= 1'b1;
						count <= 2'd0;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/c1Top.sv
`timescale 1ns/1ps
`default_nettype none

module c1Top (
	input wire CLK_68KCLK,
	input wire rstN,
	input wire [20:16] addr,
	input wire a22,
	input wire a23,
	input wire ldsN,
	input wire udsN,
	input wire rw,
	input wire asN,
	input wire [c1Pkg::dataW-1:0] dataIn,
	input wire [c1Pkg::dataW-1:0] sdd,
	input wire [9:0] p1In,
	input wire [9:0] p2In,
	input wire cd1N,
	input wire cd2N,
	input wire wpN,
	input wire romWait,
	input wire pWait0,
	input wire pWait1,
	input wire sddWr,
	output wire [c1Pkg::dataW-1:0] dataOut,
	output wire dataOe,
	output wire dtackN,
	output wire sdwN,
	output wire [c1Pkg::dataW-1:0] soundCmd,
	output wire romOeL,
	output wire romOeU,
	output wire portOeL,
	output wire portOeU,
	output wire portWeL,
	output wire portWeU,
	output wire portAdrsN,
	output wire wrL,
	output wire wrU,
	output wire wwL,
	output wire wwU,
	output wire sromOeL,
	output wire sromOeU,
	output wire sramOeL,
	output wire sramOeU,
	output wire sramWeL,
	output wire sramWeU,
	output wire lspOeN,
	output wire lspWeN,
	output wire crdOeN,
	output wire crdWeN,
	output wire crdCN,
	output wire bitW0N,
	output wire bitW1N,
	output wire dipRd0N,
	output wire dipRd1N,
	output wire palN
);

	c1Pkg::zoneT zone;
	wire ctrl1Sel;
	wire ctrl2Sel;
	wire statusSel;
	wire icomSel;

	addrDecode u_addrDecode (
		.addr(addr),
		.a22(a22),
		.a23(a23),
		.ldsN(ldsN),
		.udsN(udsN),
		.rw(rw),
		.asN(asN),
		.zone(zone),
		.ctrl1Sel(ctrl1Sel),
		.ctrl2Sel(ctrl2Sel),
		.statusSel(statusSel),
		.icomSel(icomSel),
		.romOeL(romOeL),
		.romOeU(romOeU),
		.portOeL(portOeL),
		.portOeU(portOeU),
		.portWeL(portWeL),
		.portWeU(portWeU),
		.portAdrsN(portAdrsN),
		.wrL(wrL),
		.wrU(wrU),
		.wwL(wwL),
		.wwU(wwU),
		.sromOeL(sromOeL),
		.sromOeU(sromOeU),
		.sramOeL(sramOeL),
		.sramOeU(sramOeU),
		.sramWeL(sramWeL),
		.sramWeU(sramWeU),
		.lspOeN(lspOeN),
		.lspWeN(lspWeN),
		.crdOeN(crdOeN),
		.crdWeN(crdWeN),
		.crdCN(crdCN),
		.bitW0N(bitW0N),
		.bitW1N(bitW1N),
		.dipRd0N(dipRd0N),
		.dipRd1N(dipRd1N),
		.palN(palN)
	);

	ioRegs u_ioRegs (
		.CLK_68KCLK(CLK_68KCLK),
		.rstN(rstN),
		.asN(asN),
		.rw(rw),
		.ctrl1Sel(ctrl1Sel),
		.ctrl2Sel(ctrl2Sel),
		.statusSel(statusSel),
		.icomSel(icomSel),
		.dataIn(dataIn),
		.p1In(p1In),
		.p2In(p2In),
		.cd1N(cd1N),
		.cd2N(cd2N),
		.wpN(wpN),
		.sdd(sdd),
		.sddWr(sddWr),
		.dataOut(dataOut),
		.dataOe(dataOe),
		.soundCmd(soundCmd),
		.sdwN(sdwN)
	);

	waitGen u_waitGen (
		.CLK_68KCLK(CLK_68KCLK),
		.rstN(rstN),
		.asN(asN),
		.zone(zone),
		.romWait(romWait),
		.pWait0(pWait0),
		.pWait1(pWait1),
		.dtackN(dtackN)
	);

endmodule

`default_nettype wire

//--- tests/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen (
	output logic clk
);

	// 8 ns period, starts low
	initial
	begin
		clk = 1'b0;
		forever #4 clk = !clk;
	end

endmodule

`default_nettype wire

//--- tests/c1Tb.sv
`timescale 1ns/1ps
`default_nettype none

module c1Tb;

	wire CLK_68KCLK;
	logic rstN;
	logic [20:16] addr;
	logic a22;
	logic a23;
	logic ldsN;
	logic udsN;
	logic rw;
	logic asN;
	logic [7:0] dataIn;
	logic [7:0] sdd;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic cd1N;
	logic cd2N;
	logic wpN;
	logic romWait;
	logic pWait0;
	logic pWait1;
	logic sddWr;
	wire [7:0] dataOut;
	wire dataOe;
	wire dtackN;
	wire sdwN;
	wire [7:0] soundCmd;
	wire romOeL, romOeU, portOeL, portOeU, portWeL, portWeU, portAdrsN;
	wire wrL, wrU, wwL, wwU;
	wire sromOeL, sromOeU, sramOeL, sramOeU, sramWeL, sramWeU;
	wire lspOeN, lspWeN, crdOeN, crdWeN, crdCN;
	wire bitW0N, bitW1N, dipRd0N, dipRd1N, palN;
	wire [26:0] enGot;

	int seedVal;
	logic [7:0] replyModel;

	clkGen u_clkGen (
		.clk(CLK_68KCLK)
	);

	c1Top u_c1Top (.*);

	// All enables with romOeL in the top bit
	assign enGot = {romOeL, romOeU, portOeL, portOeU, portWeL, portWeU, portAdrsN,
		wrL, wrU, wwL, wwU, sromOeL, sromOeU, sramOeL, sramOeU, sramWeL, sramWeU,
		lspOeN, lspWeN, crdOeN, crdWeN, crdCN, bitW0N, bitW1N, dipRd0N, dipRd1N, palN};

	function automatic string enName(input int i);
		case (i)
			0: return "romOeL";
			1: return "romOeU";
			2: return "portOeL";
			3: return "portOeU";
			4: return "portWeL";
			5: return "portWeU";
			6: return "portAdrsN";
			7: return "wrL";
			8: return "wrU";
			9: return "wwL";
			10: return "wwU";
			11: return "sromOeL";
			12: return "sromOeU";
			13: return "sramOeL";
			14: return "sramOeU";
			15: return "sramWeL";
			16: return "sramWeU";
			17: return "lspOeN";
			18: return "lspWeN";
			19: return "crdOeN";
			20: return "crdWeN";
			21: return "crdCN";
			22: return "bitW0N";
			23: return "bitW1N";
			24: return "dipRd0N";
			25: return "dipRd1N";
			default: return "palN";
		endcase
	endfunction

	// Memory map on {a23, a22, a20..a16}
	function automatic c1Pkg::zoneT expZone(input logic [6:0] hi, input logic uds,
		input logic isRead, input logic as);
		if (as)
			return c1Pkg::zNone;
		casez (hi)
			7'b0000???: return c1Pkg::zRom;
			7'b0001???: return c1Pkg::zWram;
			7'b0010???: return c1Pkg::zPort;
			7'b0011000: return !uds ? c1Pkg::zCtrl1 : (isRead ? c1Pkg::zDip0 : c1Pkg::zNone);
			7'b0011001: return !uds ? c1Pkg::zIcom : (isRead ? c1Pkg::zDip1 : c1Pkg::zNone);
			7'b001101?: return c1Pkg::zCtrl2;
			7'b0011100: return !uds ? c1Pkg::zStatusB : (!isRead ? c1Pkg::zBitw0 : c1Pkg::zNone);
			7'b0011101: return !uds ? c1Pkg::zStatusB : (!isRead ? c1Pkg::zBitw1 : c1Pkg::zNone);
			7'b001111?: return c1Pkg::zLspc;
			7'b01?????: return c1Pkg::zPal;
			7'b10?????: return c1Pkg::zCard;
			7'b1100???: return c1Pkg::zSrom;
			7'b1101???: return c1Pkg::zSram;
			default: return c1Pkg::zNone;
		endcase
	endfunction

	function automatic logic [26:0] expEnables(input logic [6:0] hi, input logic lds,
		input logic uds, input logic isRead, input logic as);
		logic act, word, rdLo, rdHi, wrLo, wrHi;
		logic rom, wram, port, ctrl1, icom, stat0, stat1, lspc, pal, card, srom, sram;
		act = !as;
		word = !lds && !uds;
		rdLo = act && isRead && !lds;
		rdHi = act && isRead && !uds;
		wrLo = act && !isRead && !lds;
		wrHi = act && !isRead && !uds;
		rom = hi[6:3] == 4'b0000;
		wram = hi[6:3] == 4'b0001;
		port = hi[6:3] == 4'b0010;
		ctrl1 = hi == 7'b0011000;
		icom = hi == 7'b0011001;
		stat0 = hi == 7'b0011100;
		stat1 = hi == 7'b0011101;
		lspc = hi[6:1] == 6'b001111;
		pal = hi[6:5] == 2'b01;
		card = hi[6:5] == 2'b10;
		srom = hi[6:3] == 4'b1100;
		sram = hi[6:3] == 4'b1101;
		return ~{rom && rdLo, rom && rdHi, port && rdLo, port && rdHi, port && wrLo,
			port && wrHi, port && act, wram && rdLo, wram && rdHi, wram && wrLo,
			wram && wrHi, srom && rdLo, srom && rdHi, sram && rdLo, sram && rdHi,
			sram && wrLo, sram && wrHi, lspc && act && isRead && word,
			lspc && act && !isRead && word, card && act && isRead && word,
			card && act && !isRead && word, card && act && word, stat0 && wrLo,
			stat1 && wrLo, ctrl1 && rdLo, icom && rdLo, pal && act};
	endfunction

	function automatic logic [7:0] expReadData(input c1Pkg::zoneT z, input logic [9:0] p1,
		input logic [9:0] p2, input logic c1, input logic c2, input logic wp,
		input logic [7:0] reply);
		case (z)
			c1Pkg::zCtrl1: return p1[7:0];
			c1Pkg::zCtrl2: return p2[7:0];
			c1Pkg::zStatusB: return {c1Pkg::consoleMode, wp, c2, c1, p2[9:8], p1[9:8]};
			c1Pkg::zIcom: return reply;
			default: return 8'h00;
		endcase
	endfunction

	function automatic int expWaits(input c1Pkg::zoneT z, input logic rWait,
		input logic pw1, input logic pw0);
		if (z == c1Pkg::zRom && rWait)
			return c1Pkg::romWaits;
		if (z == c1Pkg::zPort)
			return {pw1, pw0};
		if (z == c1Pkg::zCard)
			return c1Pkg::cardWaits;
		return 0;
	endfunction

	task automatic stopWithFailure;
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s is 0x%02h, expected 0x%02h", name, got, exp);
			stopWithFailure();
		end
	endtask

	task automatic checkZone(input c1Pkg::zoneT z, input logic [26:0] got,
		input logic [26:0] exp);
		for (int i = 0; i < 27; i++)
		begin
			if (got[26 - i] !== exp[26 - i])
			begin
				$display("Error: %s is 0x%0h, expected 0x%0h in zone 0x%02h",
					enName(i), got[26 - i], exp[26 - i], z);
				stopWithFailure();
			end
		end
	endtask

	// Ends on the falling edge before edge 0 of the cycle
	task automatic startCycle(input logic [6:0] hi, input logic lds, input logic uds,
		input logic isRead, input logic [7:0] d);
		@(posedge CLK_68KCLK);
		{a23, a22, addr} <= hi;
		ldsN <= lds;
		udsN <= uds;
		rw <= isRead;
		dataIn <= d;
		asN <= 1'b0;
		@(negedge CLK_68KCLK);
	endtask

	task automatic releaseBus;
		@(posedge CLK_68KCLK);
		asN <= 1'b1;
		ldsN <= 1'b1;
		udsN <= 1'b1;
		rw <= 1'b1;
		@(negedge CLK_68KCLK);
		checkBit("dtackN", dtackN, 1'b0);
		@(negedge CLK_68KCLK);
		checkBit("dtackN", dtackN, 1'b1);
	endtask

	task automatic finishCycle(input int expW);
		int n;
		n = 0;
		@(negedge CLK_68KCLK);
		while (dtackN)
		begin
			if (n == 20)
			begin
				$display("Timeout: dtackN did not fall within 20 cycles");
				stopWithFailure();
			end
			@(negedge CLK_68KCLK);
			n++;
		end
		checkByte("dtackN edge count", n[7:0], 8'(expW + 1));
		releaseBus();
	endtask

	task automatic setWaitPins(input logic rWait, input logic [1:0] pw);
		@(posedge CLK_68KCLK);
		romWait <= rWait;
		{pWait1, pWait0} <= pw;
	endtask

	task automatic decodeSweep;
		logic [6:0] hi;
		logic l, u, r, s;
		for (int k = 0; k < 200; k++)
		begin
			hi = $urandom;
			l = $urandom;
			u = $urandom;
			r = $urandom;
			// Every fourth access with asN high
			s = (k % 4) == 3;
			@(posedge CLK_68KCLK);
			{a23, a22, addr} <= hi;
			ldsN <= l;
			udsN <= u;
			rw <= r;
			asN <= s;
			@(negedge CLK_68KCLK);
			checkZone(expZone(hi, u, r, s), enGot, expEnables(hi, l, u, r, s));
		end
		@(posedge CLK_68KCLK);
		asN <= 1'b1;
		ldsN <= 1'b1;
		udsN <= 1'b1;
		rw <= 1'b1;
		repeat (3) @(posedge CLK_68KCLK);
	endtask

	task automatic readRegister(input logic [6:0] hi, input logic lds, input logic uds);
		c1Pkg::zoneT z;
		logic expOe;
		@(posedge CLK_68KCLK);
		p1In <= $urandom;
		p2In <= $urandom;
		cd1N <= $urandom;
		cd2N <= $urandom;
		wpN <= $urandom;
		startCycle(hi, lds, uds, 1'b1, 8'h00);
		z = expZone(hi, uds, 1'b1, 1'b0);
		expOe = z == c1Pkg::zCtrl1 || z == c1Pkg::zCtrl2 || z == c1Pkg::zStatusB
			|| z == c1Pkg::zIcom;
		checkBit("dataOe", dataOe, expOe);
		if (expOe)
			checkByte("dataOut", dataOut,
				expReadData(z, p1In, p2In, cd1N, cd2N, wpN, replyModel));
		finishCycle(expWaits(z, romWait, pWait1, pWait0));
	endtask

	task automatic soundLatchTest;
		logic [7:0] val;
		int n;
		val = $urandom;
		startCycle(7'b0011001, 1'b1, 1'b0, 1'b0, val);
		n = 0;
		while (sdwN)
		begin
			if (n == 20)
			begin
				$display("Timeout: sdwN did not fall within 20 cycles");
				stopWithFailure();
			end
			@(negedge CLK_68KCLK);
			n++;
		end
		// Pulse starts on the edge after the capture edge
		checkByte("sdwN edge count", n[7:0], 8'd2);
		checkByte("soundCmd", soundCmd, val);
		@(negedge CLK_68KCLK);
		checkBit("sdwN", sdwN, 1'b1);
		releaseBus();
		// No second pulse for the same write
		repeat (4)
		begin
			@(negedge CLK_68KCLK);
			checkBit("sdwN", sdwN, 1'b1);
		end
		val = $urandom;
		@(posedge CLK_68KCLK);
		sddWr <= 1'b1;
		sdd <= val;
		@(posedge CLK_68KCLK);
		sddWr <= 1'b0;
		sdd <= ~val;
		replyModel = val;
		readRegister(7'b0011001, 1'b1, 1'b0);
	endtask

	task automatic timedCycle(input logic [6:0] hi);
		startCycle(hi, 1'b0, 1'b0, 1'b1, 8'h00);
		finishCycle(expWaits(expZone(hi, 1'b0, 1'b1, 1'b0), romWait, pWait1, pWait0));
	endtask

	task automatic abortTest;
		setWaitPins(1'b0, 2'd0);
		startCycle(7'b1000000, 1'b0, 1'b0, 1'b1, 8'h00);
		// Released after edge 1 of a two-wait card cycle
		@(posedge CLK_68KCLK);
		@(posedge CLK_68KCLK);
		asN <= 1'b1;
		ldsN <= 1'b1;
		udsN <= 1'b1;
		repeat (5)
		begin
			@(negedge CLK_68KCLK);
			checkBit("dtackN", dtackN, 1'b1);
		end
		timedCycle(7'b0001000);
	endtask

	initial
	begin
		seedVal = $urandom(42);
		replyModel = 8'h00;
		rstN <= 1'b0;
		addr <= '0;
		a22 <= 1'b0;
		a23 <= 1'b0;
		ldsN <= 1'b1;
		udsN <= 1'b1;
		rw <= 1'b1;
		asN <= 1'b1;
		dataIn <= 8'h00;
		sdd <= 8'h00;
		p1In <= '0;
		p2In <= '0;
		cd1N <= 1'b1;
		cd2N <= 1'b1;
		wpN <= 1'b1;
		romWait <= 1'b0;
		pWait0 <= 1'b0;
		pWait1 <= 1'b0;
		sddWr <= 1'b0;
		repeat (3) @(posedge CLK_68KCLK);
		rstN <= 1'b1;

		@(negedge CLK_68KCLK);
		checkBit("dtackN", dtackN, 1'b1);
		checkBit("sdwN", sdwN, 1'b1);
		checkByte("soundCmd", soundCmd, 8'h00);
		checkZone(c1Pkg::zNone, enGot, '1);

		decodeSweep();

		repeat (4)
		begin
			readRegister(7'b0011000, 1'b0, 1'b0);
			readRegister(7'b0011010, 1'b1, 1'b0);
			readRegister(7'b0011011, 1'b0, 1'b0);
			readRegister(7'b0011100, 1'b0, 1'b0);
			readRegister(7'b0011101, 1'b1, 1'b0);
			readRegister(7'b0011000, 1'b0, 1'b1);
			readRegister(7'b0000101, 1'b0, 1'b0);
			readRegister(7'b0001000, 1'b0, 1'b0);
			readRegister(7'b0100000, 1'b0, 1'b0);
		end

		soundLatchTest();

		setWaitPins(1'b0, 2'd0);
		timedCycle(7'b0000010);
		setWaitPins(1'b1, 2'd0);
		timedCycle(7'b0000010);
		for (int w = 0; w < 4; w++)
		begin
			setWaitPins(1'b0, w[1:0]);
			timedCycle(7'b0010100);
		end
		timedCycle(7'b1000000);
		timedCycle(7'b0001000);

		abortTest();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/c1Pkg.sv
decode/addrDecode.sv
io/ioRegs.sv
hw/waitGen.sv
hw/c1Top.sv
tests/clkGen.sv
tests/c1Tb.sv

//--- Bender.yml
package:
  name: c1glue

sources:
  - common/c1Pkg.sv
  - decode/addrDecode.sv
  - io/ioRegs.sv
  - hw/waitGen.sv
  - hw/c1Top.sv
  - target: test
    files:
      - tests/clkGen.sv
      - tests/c1Tb.sv
